// ==== Makefile ====
SRCS := $(shell cat verilog.f)

obj_dir/VlsuTb: verilog.f $(SRCS)
	verilator --binary --timing --top-module lsuTb -f verilog.f -o VlsuTb

run: obj_dir/VlsuTb verif/lsuStimulus.txt
	./obj_dir/VlsuTb | tee sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== rtl/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input wire logic clk,
    input wire logic rstN,
    input wire logic memReqValid,
    input wire memBusPkg::memReq memReqData,
    output logic memAck,
    output memBusPkg::memRsp memRspData
);
    import rvIsaPkg::*;

    dataWord ram [memWords]; // word organized storage
    logic doAccess; // first cycle of a new request
    logic doWrite;

    // act once per handshake, while ack is still low
    assign doAccess = memReqValid && !memAck;
    assign doWrite = doAccess && memReqData.write;

    // byte lane writes on the rising edge
    always_ff @(posedge clk)
    begin
        if (doWrite)
        begin
            for (int i = 0; i < xlen/8; i++)
            begin
                if (memReqData.byteEn[i])
                begin
                    ram[memReqData.wordAddr].bytes[i] <= memReqData.wdata.bytes[i];
                end
            end
        end
    end

    // four-phase responder
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            memAck <= 1'b0;
            memRspData <= '0;
        end
        else if (doAccess)
        begin
            memAck <= 1'b1; // ack together with the access
            if (!memReqData.write)
            begin
                memRspData.rdata <= ram[memReqData.wordAddr]; // registered read word
            end
        end
        else if (!memReqValid && memAck)
        begin
            memAck <= 1'b0; // requester released, return to zero
        end
    end

endmodule

`default_nettype wire

// ==== rtl/loadExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadExtend (
    input wire rvIsaPkg::dataWord word,
    input wire logic [1:0] offset,
    input wire logic [rvIsaPkg::func3Width-1:0] func3,
    output rvIsaPkg::dataWord value
);
    import rvIsaPkg::*;

    logic [7:0] selByte; // addressed byte lane
    logic [15:0] selHalf; // addressed halfword lane

    // lane pick through the two views of the union
    assign selByte = word.bytes[offset];
    assign selHalf = word.halves[offset[1]]; // offset[0] is zero for legal halfwords

    always_comb
    begin
        case (func3)
            func3LB:
            begin
                value = {{(xlen-8){selByte[7]}}, selByte}; // sign extend byte
            end
            func3LH:
            begin
                value = {{(xlen-16){selHalf[15]}}, selHalf}; // sign extend half
            end
            func3LW:
            begin
                value = word; // whole word
            end
            func3LBU:
            begin
                value = {{(xlen-8){1'b0}}, selByte}; // zero extend byte
            end
            func3LHU:
            begin
                value = {{(xlen-16){1'b0}}, selHalf}; // zero extend half
            end
            default:
            begin
                value = '0; // refused as misaligned anyway
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lsuCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuCtrl (
    input wire logic clk,
    input wire logic rstN,
    input wire logic cpuReq,
    input wire memBusPkg::lsuReq cpuReqData,
    output logic cpuAck,
    output memBusPkg::lsuRsp cpuRsp,
    input wire logic misaligned,
    input wire rvIsaPkg::dataWord laneData,
    input wire rvIsaPkg::byteEnable byteEn,
    input wire rvIsaPkg::dataWord loadValue,
    output rvIsaPkg::dataWord loadWord,
    output logic memReqValid,
    output memBusPkg::memReq memReqData,
    input wire logic memAck,
    input wire memBusPkg::memRsp memRspData
);
    import rvIsaPkg::*;

    typedef enum logic [2:0] {
        sIdle, // waiting for cpuReq
        sMemReq, // memReqValid high, waiting for memAck
        sMemRel, // memReqValid low, waiting for memAck to drop
        sCoreAck, // cpuAck high, waiting for cpuReq to drop
        sCoreRel // ack low for one cycle before the next request
    } ctrlState;

    ctrlState state;

    // control part of the FSM
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= sIdle;
            cpuAck <= 1'b0;
            cpuRsp <= '0;
            memReqValid <= 1'b0;
        end
        else
        begin
            case (state)
                sIdle:
                begin
                    if (cpuReq && misaligned)
                    begin
                        cpuRsp <= '{rdata: '0, misaligned: 1'b1}; // refused, no memory access
                        cpuAck <= 1'b1;
                        state <= sCoreAck;
                    end
                    else if (cpuReq)
                    begin
                        memReqValid <= 1'b1; // start memory handshake
                        state <= sMemReq;
                    end
                end
                sMemReq:
                begin
                    if (memAck)
                    begin
                        memReqValid <= 1'b0; // release the memory
                        state <= sMemRel;
                    end
                end
                sMemRel:
                begin
                    if (!memAck)
                    begin
                        // loadWord was captured one cycle earlier, loadValue settled
                        cpuRsp.rdata <= cpuReqData.write ? dataWord'('0) : loadValue;
                        cpuRsp.misaligned <= 1'b0;
                        cpuAck <= 1'b1;
                        state <= sCoreAck;
                    end
                end
                sCoreAck:
                begin
                    if (!cpuReq)
                    begin
                        cpuAck <= 1'b0; // requester done, return to zero
                        state <= sCoreRel;
                    end
                end
                default:
                begin
                    state <= sIdle; // sCoreRel and any stray code
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (state == sIdle && cpuReq)
        begin
            memReqData <= '{
                write: cpuReqData.write,
                wordAddr: cpuReqData.addr[wordAddrWidth+1:2],
                wdata: laneData,
                byteEn: byteEn
            };
        end
        if (state == sMemReq && memAck)
        begin
            loadWord <= memRspData.rdata; // raw word for loadExtend
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop (
    input wire logic clk,
    input wire logic rstN,
    input wire logic cpuReq,
    input wire memBusPkg::lsuReq cpuReqData,
    output logic cpuAck,
    output memBusPkg::lsuRsp cpuRsp
);
    import rvIsaPkg::*;
    import memBusPkg::*;

    dataWord laneData; // store data steered into lanes
    byteEnable byteEn;
    logic misaligned;
    dataWord loadWord; // raw word from memory
    dataWord loadValue; // extended load result
    logic memReqValid;
    logic memAck;
    memReq memReqData;
    memRsp memRspData;

    storeAlign i_storeAlign (
        .req(cpuReqData),
        .laneData(laneData),
        .byteEn(byteEn),
        .misaligned(misaligned)
    );

    // offset and funct3 come from the request, stable until cpuAck
    loadExtend i_loadExtend (
        .word(loadWord),
        .offset(cpuReqData.addr[1:0]),
        .func3(cpuReqData.func3),
        .value(loadValue)
    );

    lsuCtrl i_lsuCtrl (
        .clk(clk),
        .rstN(rstN),
        .cpuReq(cpuReq),
        .cpuReqData(cpuReqData),
        .cpuAck(cpuAck),
        .cpuRsp(cpuRsp),
        .misaligned(misaligned),
        .laneData(laneData),
        .byteEn(byteEn),
        .loadValue(loadValue),
        .loadWord(loadWord),
        .memReqValid(memReqValid),
        .memReqData(memReqData),
        .memAck(memAck),
        .memRspData(memRspData)
    );

    dataMem i_dataMem (
        .clk(clk),
        .rstN(rstN),
        .memReqValid(memReqValid),
        .memReqData(memReqData),
        .memAck(memAck),
        .memRspData(memRspData)
    );

endmodule

`default_nettype wire

// ==== rtl/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

    // core side request, held stable while cpuReq is high
    typedef struct packed {
        logic write; // 1 store, 0 load
        logic [rvIsaPkg::func3Width-1:0] func3; // size and sign of the access
        logic [rvIsaPkg::xlen-1:0] addr; // byte address
        rvIsaPkg::dataWord wdata; // store data, low bits used for sb/sh
    } lsuReq;

    // core side response, held stable while cpuAck is high
    typedef struct packed {
        rvIsaPkg::dataWord rdata; // extended load value, zero otherwise
        logic misaligned; // access refused, memory untouched
    } lsuRsp;

    // memory side request from the controller
    typedef struct packed {
        logic write; // 1 writes the enabled lanes
        logic [rvIsaPkg::wordAddrWidth-1:0] wordAddr; // word index into the RAM
        rvIsaPkg::dataWord wdata; // lane-shifted store data
        rvIsaPkg::byteEnable byteEn; // lanes to be written
    } memReq;

    // memory side response
    // the whole word is returned, lane selection happens in the unit
    typedef struct packed {
        rvIsaPkg::dataWord rdata; // registered read word
    } memRsp;

endpackage

`default_nettype wire

// ==== rtl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // word and address width of RV32I
    localparam int xlen = 32;
    localparam int func3Width = 3; // width of the funct3 field

    // data memory geometry
    localparam int memWords = 1024;
    localparam int wordAddrWidth = 10; // log2 of memWords

    // load encodings
    localparam logic [func3Width-1:0] func3LB = 3'd0;
    localparam logic [func3Width-1:0] func3LH = 3'd1;
    localparam logic [func3Width-1:0] func3LW = 3'd2;
    localparam logic [func3Width-1:0] func3LBU = 3'd4;
    localparam logic [func3Width-1:0] func3LHU = 3'd5;

    // store encodings
    localparam logic [func3Width-1:0] func3SB = 3'd0;
    localparam logic [func3Width-1:0] func3SH = 3'd1;
    localparam logic [func3Width-1:0] func3SW = 3'd2;

    // one data word, seen either as bytes or as halfwords
    // lane 0 holds the least significant byte (little endian)
    typedef union packed {
        logic [xlen/8-1:0][7:0] bytes; // four byte lanes
        logic [xlen/16-1:0][15:0] halves; // two halfword lanes
    } dataWord;

    // one write enable per byte lane
    typedef logic [xlen/8-1:0] byteEnable;

endpackage

`default_nettype wire

// ==== rtl/storeAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeAlign (
    input wire memBusPkg::lsuReq req,
    output rvIsaPkg::dataWord laneData,
    output rvIsaPkg::byteEnable byteEn,
    output logic misaligned
);
    import rvIsaPkg::*;

    logic [1:0] offset; // byte offset inside the word

    assign offset = req.addr[1:0];

    // funct3[1:0] is the access size for loads and stores alike
    always_comb
    begin
        case (req.func3[1:0])
            2'd0:
            begin
                laneData.bytes = {4{req.wdata.bytes[0]}}; // byte copied to every lane
                byteEn = byteEnable'(4'b0001) << offset; // only the addressed lane
            end
            2'd1:
            begin
                laneData.halves = {2{req.wdata.halves[0]}}; // halfword in both halves
                byteEn = byteEnable'(4'b0011) << offset; // lower or upper half
            end
            default:
            begin
                laneData = req.wdata; // full word as is
                byteEn = '1;
            end
        endcase
    end

    // alignment and encoding check, separate tables for loads and stores
    always_comb
    begin
        if (req.write)
        begin
            case (req.func3)
                func3SB: misaligned = 1'b0; // bytes never misaligned
                func3SH: misaligned = offset[0]; // odd offset
                func3SW: misaligned = |offset;
                default: misaligned = 1'b1; // no such store
            endcase
        end
        else
        begin
            case (req.func3)
                func3LB, func3LBU: misaligned = 1'b0;
                func3LH, func3LHU: misaligned = offset[0];
                func3LW: misaligned = |offset;
                default: misaligned = 1'b1; // funct3 3, 6, 7 undefined
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verif/lsuStimulus.txt ====
# each line holds write func3 addr wdata expRdata expMisaligned in hex
# lines starting with # are skipped
1 2 00000100 deadbeef 00000000 0
0 2 00000100 00000000 deadbeef 0
1 2 00000ffc a5a50ff0 00000000 0
0 2 00000ffc 00000000 a5a50ff0 0
1 0 00000200 000000a1 00000000 0
1 0 00000201 ffffff72 00000000 0
1 0 00000202 5555aac3 00000000 0
1 0 00000203 87654314 00000000 0
0 2 00000200 00000000 14c372a1 0
0 0 00000200 00000000 ffffffa1 0
0 4 00000200 00000000 000000a1 0
0 0 00000201 00000000 00000072 0
0 4 00000201 00000000 00000072 0
0 0 00000202 00000000 ffffffc3 0
0 4 00000202 00000000 000000c3 0
0 0 00000203 00000000 00000014 0
0 4 00000203 00000000 00000014 0
1 2 00000300 12348765 00000000 0
0 1 00000300 00000000 ffff8765 0
0 5 00000300 00000000 00008765 0
0 1 00000302 00000000 00001234 0
0 5 00000302 00000000 00001234 0
1 1 00000302 9999c001 00000000 0
0 2 00000300 00000000 c0018765 0
0 1 00000302 00000000 ffffc001 0
0 5 00000302 00000000 0000c001 0
1 0 00000103 0000005a 00000000 0
0 2 00000100 00000000 5aadbeef 0
1 1 00000301 ffffffff 00000000 1
1 1 00000303 ffffffff 00000000 1
1 2 00000302 ffffffff 00000000 1
1 3 00000300 ffffffff 00000000 1
1 4 00000300 ffffffff 00000000 1
0 1 00000201 00000000 00000000 1
0 5 00000203 00000000 00000000 1
0 2 00000101 00000000 00000000 1
0 3 00000100 00000000 00000000 1
0 6 00000200 00000000 00000000 1
0 7 00000300 00000000 00000000 1
0 2 00000300 00000000 c0018765 0
0 2 00000100 00000000 5aadbeef 0
0 2 00000200 00000000 14c372a1 0

// ==== verif/lsuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTb;
    import rvIsaPkg::*;
    import memBusPkg::*;

    localparam int clkPeriod = 20; // ns
    localparam int resetCycles = 8;
    localparam int ackLimit = 20; // cycles allowed for each ack edge
    localparam int cyclesPerAccess = 40; // watchdog budget per stimulus line

    logic clk;
    logic rstN;
    logic cpuReq;
    lsuReq cpuReqData;
    logic cpuAck;
    lsuRsp cpuRsp;

    lsuReq reqList [$]; // one request per stimulus line
    dataWord expData [$];
    logic expFlag [$];
    int lineCount;
    bit loaded; // set once the stimulus is read
    int mismatchCount;
    int protoCount; // handshake failures
    int ackCount; // rising edges of cpuAck
    logic ackPrev;
    logic [31:0] lfsr;

    lsuTop i_dut (
        .clk(clk),
        .rstN(rstN),
        .cpuReq(cpuReq),
        .cpuReqData(cpuReqData),
        .cpuAck(cpuAck),
        .cpuRsp(cpuRsp)
    );

    initial clk = 1'b0;
    always #(clkPeriod/2) clk = ~clk;

    // every ack rise is one completed access
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            ackPrev <= 1'b0;
        end
        else
        begin
            if (cpuAck && !ackPrev)
            begin
                ackCount <= ackCount + 1;
            end
            ackPrev <= cpuAck;
        end
    end

    // polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic drawIdle(output int cycles);
        cycles = 0;
        for (int i = 0; i < 3; i++)
        begin
            lfsr = nextLfsr(lfsr); // one step per bit taken
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1; // drive and sample just after the edge
        end
    endtask

    task automatic checkData(input string name, input int idx, input dataWord got,
                             input dataWord exp);
        if (got !== exp)
        begin
            $display("mismatch %s at access %0d: got %h expected %h", name, idx, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkFlag(input string name, input int idx, input logic got,
                             input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s at access %0d: got %h expected %h", name, idx, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic waitAck(input logic level, output bit seen);
        int n;
        n = 0;
        seen = (cpuAck === level);
        while (!seen && n < ackLimit)
        begin
            idleCycles(1);
            n++;
            seen = (cpuAck === level);
        end
    endtask

    task automatic loadStimulus(output bit ok);
        int fd;
        int n;
        string line;
        logic [31:0] f [6];
        lsuReq req;
        fd = $fopen("verif/lsuStimulus.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0)
            begin
                n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                if (n == 6) // comment lines yield no fields
                begin
                    req.write = f[0][0];
                    req.func3 = f[1][2:0];
                    req.addr = f[2];
                    req.wdata = f[3];
                    reqList.push_back(req);
                    expData.push_back(f[4]);
                    expFlag.push_back(f[5][0]);
                end
            end
        end
        if (ok)
        begin
            $fclose(fd);
        end
        lineCount = reqList.size();
        ok = ok && (lineCount > 0);
    endtask

    // one full four-phase exchange with random waits on both sides
    task automatic runAccess(input int idx);
        int idle;
        bit seen;
        lsuRsp rsp;
        drawIdle(idle);
        idleCycles(idle);
        cpuReqData = reqList[idx];
        cpuReq = 1'b1;
        waitAck(1'b1, seen);
        if (!seen)
        begin
            $display("no acknowledge for access %0d within %0d cycles", idx, ackLimit);
            protoCount++;
        end
        else
        begin
            rsp = cpuRsp;
            checkData("cpuRsp.rdata", idx, rsp.rdata, expData[idx]);
            checkFlag("cpuRsp.misaligned", idx, rsp.misaligned, expFlag[idx]);
            drawIdle(idle);
            for (int k = 0; k < idle; k++)
            begin
                idleCycles(1); // request held after ack
                if (cpuAck !== 1'b1)
                begin
                    $display("acknowledge for access %0d dropped before release", idx);
                    protoCount++;
                end
                checkData("held cpuRsp.rdata", idx, cpuRsp.rdata, expData[idx]);
                checkFlag("held cpuRsp.misaligned", idx, cpuRsp.misaligned, expFlag[idx]);
            end
        end
        cpuReq = 1'b0; // data stays until the next request
        waitAck(1'b0, seen);
        if (!seen)
        begin
            $display("acknowledge for access %0d never dropped after release", idx);
            protoCount++;
        end
    endtask

    initial
    begin
        bit ok;
        rstN = 1'b0;
        cpuReq = 1'b0;
        cpuReqData = '0;
        lfsr = 32'he8c5;
        loadStimulus(ok);
        if (!ok)
        begin
            $display("stimulus file verif/lsuStimulus.txt is missing or holds no accesses");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            loaded = 1'b1;
            idleCycles(resetCycles);
            rstN = 1'b1;
            for (int i = 0; i < lineCount; i++)
            begin
                runAccess(i);
            end
            idleCycles(2); // last ack edge counted
            if (ackCount != lineCount)
            begin
                $display("saw %0d acknowledges for %0d accesses", ackCount, lineCount);
                protoCount++;
            end
            $display("errors: %0d mismatches, %0d handshake failures in %0d accesses",
                     mismatchCount, protoCount, lineCount);
            if (mismatchCount == 0 && protoCount == 0)
            begin
                $display("TEST PASSED");
            end
            else
            begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // watchdog sized from the number of accesses
    initial
    begin
        wait (loaded);
        #((lineCount * cyclesPerAccess + resetCycles) * clkPeriod);
        $display("watchdog expired before %0d accesses completed", lineCount);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/rvIsaPkg.sv
rtl/memBusPkg.sv
rtl/storeAlign.sv
rtl/loadExtend.sv
rtl/dataMem.sv
rtl/lsuCtrl.sv
rtl/lsuTop.sv
verif/lsuTb.sv
